/* src/ethRx_params.svh */
/*
  Shared constants of the 10BASE-T receiver
  Timing values count clkRx periods; one line bit lasts RX_BIT_CYCLES
  RX_BLANK_CYCLES must lie between half a bit and a whole bit
  RX_IDLE_CYCLES must exceed one bit so that a running frame never ends
  STATION_MAC holds the first byte on the line in its top bits
*/
`ifndef ETHRX_PARAMS_SVH
`define ETHRX_PARAMS_SVH

////////////////////////////////////////
// Line timing

// Clock periods per Manchester bit
`define RX_BIT_CYCLES 8
// Blanking after an accepted mid-bit edge, hides the bit boundary edge
`define RX_BLANK_CYCLES 6
// Silence on the line that closes a frame
`define RX_IDLE_CYCLES 12

////////////////////////////////////////
// Framing

// Preamble bits needed before an SFD is trusted
`define PREAMBLE_MIN_BITS 31
// Smallest UDP frame after the SFD, header plus payload plus CRC
`define MIN_FRAME_BYTES 64
// Patterns as seen in the LSB-first shift register
`define PREAMBLE_BYTE 8'h55
`define SFD_BYTE 8'hD5

////////////////////////////////////////
// CRC-32 and address

// Ethernet polynomial, MSB-first form
`define CRC_POLY 32'h04C11DB7
// Register contents after a frame followed by its own CRC
`define CRC_RESIDUE 32'hC704DD7B
// Station address, not a broadcast address
`define STATION_MAC 48'h5A96_6020_D439

`endif

/* src/ethRxPkg.sv */
/*
  Types shared by the receiver blocks
  Widths are fixed here; bitCountT covers a full 1518-byte frame
  The decoder has two states only, all bit timing comes from counters
*/
package ethRxPkg;

	////////////////////////////////////////
	// Data path vectors

	// One received byte
	typedef logic [7:0] rxByteT;

	// Frame bits since the SFD, 14 bits hold 1518 bytes
	typedef logic [13:0] bitCountT;

	// Serial CRC-32 register
	typedef logic [31:0] crcT;

	// Ethernet MAC address
	typedef logic [47:0] macT;

	// Accepted frame counter, wraps silently
	typedef logic [31:0] pktCountT;

	////////////////////////////////////////
	// Decoder FSM

	// huntEdge waits for a mid-bit edge
	// blank ignores the line until the next mid-bit edge is near
	typedef enum logic {
		huntEdge,
		blank
	} decStateT;

endpackage

/* src/manchesterDecoder.sv */
/*
  Manchester bit recovery on the rising edge of clkRx
  rxLine is asynchronous and passes a two-flop synchronizer
  Locks to mid-bit edges, so the first bit of a burst may be wrong
  The preamble absorbs that; polarity toggles on each sfdFlip strobe
*/
`timescale 1ns/1ps
`include "ethRx_params.svh"

module manchesterDecoder (
	input  logic clkRx,
	input  logic arstN,
	input  logic rxLine,
	input  logic sfdFlip,
	output logic bitValid,
	output logic bitData,
	output logic frameEnd
);

	localparam int blankW = $clog2(`RX_BLANK_CYCLES + 1);
	localparam int idleW  = $clog2(`RX_IDLE_CYCLES + 1);

	logic syncA;
	logic syncB;
	logic lineLast;
	logic lineEdge;
	logic polarity;
	ethRxPkg::decStateT state;
	logic [blankW-1:0] blankCnt;
	logic [idleW-1:0] idleCnt;

	// Any change of the synchronized line, independent of polarity
	assign lineEdge = syncB ^ lineLast;

	////////////////////////////////////////
	// Synchronizer, edge history, polarity
	always_ff @(posedge clkRx or negedge arstN)
	begin
		if (!arstN)
		begin
			syncA    <= 1'b0;
			syncB    <= 1'b0;
			lineLast <= 1'b0;
			polarity <= 1'b0;
		end
		else
		begin
			syncA    <= rxLine;
			syncB    <= syncA;
			lineLast <= syncB;
			// Frame sync saw the inverted SFD
			if (sfdFlip)
				polarity <= ~polarity;
		end
	end

	////////////////////////////////////////
	// Bit FSM and idle timer
	always_ff @(posedge clkRx or negedge arstN)
	begin
		if (!arstN)
		begin
			state    <= ethRxPkg::huntEdge;
			blankCnt <= '0;
			bitValid <= 1'b0;
			idleCnt  <= idleW'(`RX_IDLE_CYCLES);
			frameEnd <= 1'b0;
		end
		else
		begin
			bitValid <= 1'b0;
			case (state)
				ethRxPkg::huntEdge:
				begin
					// New level after the mid-bit edge is the bit value
					if (lineEdge)
					begin
						bitValid <= 1'b1;
						blankCnt <= '0;
						state    <= ethRxPkg::blank;
					end
				end
				default:
				begin
					// Boundary edges fall in here and are dropped
					if (blankCnt == blankW'(`RX_BLANK_CYCLES - 1))
						state <= ethRxPkg::huntEdge;
					else
						blankCnt <= blankCnt + 1'b1;
				end
			endcase
			// Saturating counter gives a single frameEnd per silence
			frameEnd <= !lineEdge && (idleCnt == idleW'(`RX_IDLE_CYCLES - 1));
			if (lineEdge)
				idleCnt <= '0;
			else if (idleCnt != idleW'(`RX_IDLE_CYCLES))
				idleCnt <= idleCnt + 1'b1;
		end
	end

	// Bit value, only meaningful with bitValid
	always_ff @(posedge clkRx)
	begin
		if (state == ethRxPkg::huntEdge && lineEdge)
			bitData <= syncB ^ polarity;
	end

endmodule

/* src/frameSync.sv */
/*
  Preamble and SFD hunt, bit counting and byte assembly
  Bits arrive LSB first; a byte is the last eight bits at each boundary
  The preamble may appear in either polarity; an inverted SFD asks the
  decoder to flip, so the frame body is always seen upright
  Outputs follow bitValid by one cycle; frameEnd closes the frame
*/
`timescale 1ns/1ps
`include "ethRx_params.svh"

module frameSync (
	input  logic clkRx,
	input  logic arstN,
	input  logic bitValid,
	input  logic bitData,
	input  logic frameEnd,
	output logic sfd,
	output logic sfdFlip,
	output logic inFrame,
	output ethRxPkg::rxByteT rxByte,
	output logic rxByteValid,
	output ethRxPkg::bitCountT bitCount
);

	localparam int preW = $clog2(`PREAMBLE_MIN_BITS + 1);

	ethRxPkg::rxByteT shiftReg;
	ethRxPkg::rxByteT shiftNext;
	logic [preW-1:0] preCnt;
	logic preambleSeen;
	logic preambleBits;
	logic sfdHit;
	logic byteHit;

	// Window including the bit that arrives now
	assign shiftNext = {bitData, shiftReg[7:1]};

	// Alternating pattern in either polarity
	assign preambleBits = (shiftNext == `PREAMBLE_BYTE) || (shiftNext == ~`PREAMBLE_BYTE);
	assign preambleSeen = (preCnt == preW'(`PREAMBLE_MIN_BITS));

	// SFD is only looked for between frames
	assign sfdHit = bitValid && !inFrame && preambleSeen &&
		((shiftNext == `SFD_BYTE) || (shiftNext == ~`SFD_BYTE));

	// Eighth bit of a byte inside the frame
	assign byteHit = bitValid && inFrame && (bitCount[2:0] == 3'd7);

	////////////////////////////////////////
	// Shift register and preamble counter
	always_ff @(posedge clkRx or negedge arstN)
	begin
		if (!arstN)
		begin
			shiftReg <= '0;
			preCnt   <= '0;
		end
		else
		begin
			if (bitValid)
				shiftReg <= shiftNext;
			if (frameEnd)
				preCnt <= '0;
			else if (bitValid)
			begin
				// Saturate, any other pattern restarts the hunt
				if (!preambleBits)
					preCnt <= '0;
				else if (!preambleSeen)
					preCnt <= preCnt + 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// Frame state, strobes and bit count
	always_ff @(posedge clkRx or negedge arstN)
	begin
		if (!arstN)
		begin
			inFrame     <= 1'b0;
			sfd         <= 1'b0;
			sfdFlip     <= 1'b0;
			rxByteValid <= 1'b0;
			bitCount    <= '0;
		end
		else
		begin
			sfd         <= sfdHit;
			sfdFlip     <= sfdHit && (shiftNext == ~`SFD_BYTE);
			rxByteValid <= byteHit;
			if (frameEnd)
				inFrame <= 1'b0;
			else if (sfdHit)
				inFrame <= 1'b1;
			// Count stays readable in the frameEnd cycle
			if (!inFrame)
				bitCount <= '0;
			else if (bitValid)
				bitCount <= bitCount + 1'b1;
		end
	end

	// Byte register, valid with rxByteValid
	always_ff @(posedge clkRx)
	begin
		if (byteHit)
			rxByte <= shiftNext;
	end

endmodule

/* src/crcCheck.sv */
/*
  Serial CRC-32 over the frame bits in line order
  Restarts at all ones on sfd; the SFD bit itself is not included
  crcOk reflects the register after the latest whole byte and is
  valid one cycle after that byte's strobe
*/
`timescale 1ns/1ps
`include "ethRx_params.svh"

module crcCheck (
	input  logic clkRx,
	input  logic arstN,
	input  logic bitValid,
	input  logic bitData,
	input  logic sfd,
	input  logic rxByteValid,
	output logic crcOk
);

	ethRxPkg::crcT crcReg;
	logic feedback;

	// Incoming bit against the register MSB
	assign feedback = bitData ^ crcReg[31];

	////////////////////////////////////////
	// LFSR and residue check
	always_ff @(posedge clkRx or negedge arstN)
	begin
		if (!arstN)
		begin
			crcReg <= '1;
			crcOk  <= 1'b0;
		end
		else
		begin
			// Restart wins, the next bit is many cycles away anyway
			if (sfd)
				crcReg <= '1;
			else if (bitValid)
				crcReg <= {crcReg[30:0], 1'b0} ^ ({32{feedback}} & `CRC_POLY);
			// Register already holds the eighth bit of the byte
			if (rxByteValid)
				crcOk <= (crcReg == `CRC_RESIDUE);
		end
	end

endmodule

/* src/packetQualifier.sv */
/*
  Frame verdict from destination address, minimum length and CRC
  The first six bytes after the SFD must equal the station address
  Broadcast and multicast frames are not accepted
  Exactly one of pktOk and pktBad fires one cycle after frameEnd,
  only for a frame that had found its SFD
*/
`timescale 1ns/1ps
`include "ethRx_params.svh"

module packetQualifier (
	input  logic clkRx,
	input  logic arstN,
	input  ethRxPkg::rxByteT rxByte,
	input  logic rxByteValid,
	input  logic inFrame,
	input  ethRxPkg::bitCountT bitCount,
	input  logic crcOk,
	input  logic frameEnd,
	output logic pktOk,
	output logic pktBad,
	output ethRxPkg::pktCountT pktCount
);

	localparam ethRxPkg::macT stationMac = `STATION_MAC;

	logic [10:0] byteNum;
	logic [2:0] macIdx;
	ethRxPkg::rxByteT macByte;
	logic inMacField;
	logic macOk;
	logic lengthOk;
	logic frameDone;
	logic frameGood;

	// With the strobe, bitCount already counts the byte just received
	assign byteNum    = bitCount[13:3];
	assign inMacField = (byteNum != 11'd0) && (byteNum <= 11'd6);
	assign macIdx     = 3'(byteNum - 11'd1);
	// Index 0 is the first byte on the line and the top of the address
	assign macByte    = stationMac[47 - 8*macIdx -: 8];

	// Length includes the CRC bytes
	assign lengthOk  = bitCount >= ethRxPkg::bitCountT'(`MIN_FRAME_BYTES * 8);
	assign frameDone = frameEnd && inFrame;
	assign frameGood = macOk && crcOk && lengthOk;

	////////////////////////////////////////
	// Address flag, verdict and counter
	always_ff @(posedge clkRx or negedge arstN)
	begin
		if (!arstN)
		begin
			macOk    <= 1'b1;
			pktOk    <= 1'b0;
			pktBad   <= 1'b0;
			pktCount <= '0;
		end
		else
		begin
			// Armed between frames and cleared by any wrong address byte
			if (!inFrame)
				macOk <= 1'b1;
			else if (rxByteValid && inMacField && (rxByte != macByte))
				macOk <= 1'b0;
			pktOk  <= frameDone && frameGood;
			pktBad <= frameDone && !frameGood;
			// Counter moves in the same cycle as pktOk
			if (frameDone && frameGood)
				pktCount <= pktCount + 1'b1;
		end
	end

endmodule

/* src/ethRxTop.sv */
/*
  10BASE-T receive path, single clock domain
  rxLine is the positive receive pair, sampled on rising clkRx only
  Byte stream has no back-pressure; a missed rxByteValid is lost
  Verdict arrives a variable time after the last line bit
*/
`timescale 1ns/1ps

module ethRxTop (
	input  logic clkRx,
	input  logic arstN,
	input  logic rxLine,
	output ethRxPkg::rxByteT rxByte,
	output logic rxByteValid,
	output logic inFrame,
	output logic pktOk,
	output logic pktBad,
	output ethRxPkg::pktCountT pktCount
);

	logic bitValid;
	logic bitData;
	logic frameEnd;
	logic sfd;
	logic sfdFlip;
	logic crcOk;
	ethRxPkg::bitCountT bitCount;

	////////////////////////////////////////
	// Line to bits
	manchesterDecoder decoder (
		.clkRx    (clkRx),
		.arstN    (arstN),
		.rxLine   (rxLine),
		.sfdFlip  (sfdFlip),
		.bitValid (bitValid),
		.bitData  (bitData),
		.frameEnd (frameEnd)
	);

	// Bits to framed bytes
	frameSync sync (
		.clkRx       (clkRx),
		.arstN       (arstN),
		.bitValid    (bitValid),
		.bitData     (bitData),
		.frameEnd    (frameEnd),
		.sfd         (sfd),
		.sfdFlip     (sfdFlip),
		.inFrame     (inFrame),
		.rxByte      (rxByte),
		.rxByteValid (rxByteValid),
		.bitCount    (bitCount)
	);

	// CRC on the same bit stream, restarted by the SFD
	crcCheck crc (
		.clkRx       (clkRx),
		.arstN       (arstN),
		.bitValid    (bitValid),
		.bitData     (bitData),
		.sfd         (sfd),
		.rxByteValid (rxByteValid),
		.crcOk       (crcOk)
	);

	////////////////////////////////////////
	// Verdict
	packetQualifier qualifier (
		.clkRx       (clkRx),
		.arstN       (arstN),
		.rxByte      (rxByte),
		.rxByteValid (rxByteValid),
		.inFrame     (inFrame),
		.bitCount    (bitCount),
		.crcOk       (crcOk),
		.frameEnd    (frameEnd),
		.pktOk       (pktOk),
		.pktBad      (pktBad),
		.pktCount    (pktCount)
	);

endmodule

/* bench/frameGen.svh */
/*
  Frame builder and Manchester line driver for the receiver testbench
  Needs clkRx, rxLine and the byte queue txBytes in the including module
  Tasks are entered on a falling clock edge, rxLine only changes there
  Payload bytes come from $urandom, seeded once by the caller
*/
`ifndef FRAME_GEN_SVH
`define FRAME_GEN_SVH

// One byte into the reflected CRC-32, LSB first as on the line
function automatic logic [31:0] crcStep(input logic [31:0] crc, input logic [7:0] data);
	logic [31:0] c;
	int i;
	c = crc ^ {24'h0, data};
	for (i = 0; i < 8; i++)
		c = c[0] ? ((c >> 1) ^ 32'hEDB88320) : (c >> 1);
	return c;
endfunction

// Frame body after the SFD: destination, source, payload, FCS
task automatic buildFrame(input int payLen, input bit toStation, input bit corrupt);
	logic [47:0] dst;
	logic [31:0] crc;
	int i;
	// Foreign address differs in the last byte only
	dst = toStation ? `STATION_MAC : (`STATION_MAC ^ 48'h1);
	txBytes.delete();
	for (i = 0; i < 6; i++)
		txBytes.push_back(dst[47 - 8*i -: 8]);
	// Locally administered source
	for (i = 0; i < 6; i++)
		txBytes.push_back(8'(i + 2));
	for (i = 0; i < payLen; i++)
		txBytes.push_back(8'($urandom));
	crc = '1;
	for (i = 0; i < txBytes.size(); i++)
		crc = crcStep(crc, txBytes[i]);
	crc = ~crc;
	// FCS goes out least significant byte first
	for (i = 0; i < 4; i++)
		txBytes.push_back(crc[8*i +: 8]);
	// Single bit error in the payload, after the FCS is fixed
	if (corrupt)
		txBytes[17] = txBytes[17] ^ 8'h08;
endtask

// Complement first, so the mid-bit edge lands on the bit value
task automatic driveBit(input logic b, input logic invert);
	rxLine = ~b ^ invert;
	repeat (`RX_BIT_CYCLES / 2) @(negedge clkRx);
	rxLine = b ^ invert;
	repeat (`RX_BIT_CYCLES / 2) @(negedge clkRx);
endtask

task automatic driveByte(input logic [7:0] data, input logic invert);
	int i;
	for (i = 0; i < 8; i++)
		driveBit(data[i], invert);
endtask

// Preamble, SFD, body, then the line rests at its idle level
task automatic sendFrame(input int preBytes, input logic invert);
	int i;
	for (i = 0; i < preBytes; i++)
		driveByte(`PREAMBLE_BYTE, invert);
	driveByte(`SFD_BYTE, invert);
	for (i = 0; i < txBytes.size(); i++)
		driveByte(txBytes[i], invert);
	rxLine = invert;
endtask

`endif

/* bench/ethRxTb.sv */
/*
  Testbench for the 10BASE-T receive path
  Frames come from a table and are checked for verdict, bytes and count
  Line changes on the falling edge and outputs are sampled there too
  A watchdog bounds the run by the total frame length
*/
`timescale 1ns/1ps
`include "ethRx_params.svh"

module ethRxTb;

	localparam int numTests = 7;
	// Verdict codes used in the table
	localparam int verdictNone = 0;
	localparam int verdictOk = 1;
	localparam int verdictBad = 2;
	// Cycles from the last line bit to a verdict strobe
	localparam int verdictWindow = 40;
	// Quiet line before a frame is longer than the decoder idle timeout
	localparam int idleGap = 40;

	////////////////////////////////////////
	// Test table with one column per array
	int payLen [numTests] = '{48, 48, 48, 34, 48, 48, 48};
	bit toStation [numTests] = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1};
	bit corruptBit [numTests] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
	bit invertLine [numTests] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
	int preBytes [numTests] = '{7, 7, 7, 7, 7, 7, 2};
	int verdict [numTests] = '{verdictOk, verdictBad, verdictBad, verdictBad,
		verdictOk, verdictOk, verdictNone};
	string testName [numTests] = '{"good frame", "corrupted payload", "other destination",
		"short frame", "inverted line", "upright after inverted", "short preamble"};

	logic clkRx = 1'b0;
	logic arstN;
	logic rxLine;
	ethRxPkg::rxByteT rxByte;
	logic rxByteValid;
	logic inFrame;
	logic pktOk;
	logic pktBad;
	ethRxPkg::pktCountT pktCount;

	// Sent body and everything collected from the byte stream
	logic [7:0] txBytes[$];
	logic [7:0] rxBytes[$];
	// Running totals from the monitor are compared against per-test bases
	int okSeen = 0;
	int badSeen = 0;
	int inFrameCycles = 0;
	int okBase;
	int badBase;
	int byteBase;
	int inFrameBase;
	int testErrors = 0;
	int errorCount = 0;
	int failedTests = 0;
	ethRxPkg::pktCountT expectedCount = '0;

	`include "frameGen.svh"

	always #10 clkRx = ~clkRx;

	ethRxTop uut (
		.clkRx       (clkRx),
		.arstN       (arstN),
		.rxLine      (rxLine),
		.rxByte      (rxByte),
		.rxByteValid (rxByteValid),
		.inFrame     (inFrame),
		.pktOk       (pktOk),
		.pktBad      (pktBad),
		.pktCount    (pktCount)
	);

	////////////////////////////////////////
	// Output monitor samples strobes at the falling edge where they are steady
	always @(negedge clkRx)
	begin
		if (rxByteValid)
			rxBytes.push_back(rxByte);
		if (pktOk)
			okSeen++;
		if (pktBad)
			badSeen++;
		if (inFrame)
			inFrameCycles++;
	end

	task automatic checkValue(input logic [31:0] expected, input logic [31:0] actual,
		input string what);
		if (expected !== actual)
		begin
			$display("[FAIL] time %0d ns: %s expected %0h, got %0h",
				$time, what, expected, actual);
			errorCount++;
			testErrors++;
		end
	endtask

	// Stops early on a verdict and lingers to catch a second strobe
	task automatic waitVerdict();
		int n;
		n = 0;
		while ((okSeen + badSeen) == (okBase + badBase) && n < verdictWindow)
		begin
			@(negedge clkRx);
			n++;
		end
		repeat (4) @(negedge clkRx);
	endtask

	////////////////////////////////////////
	// Watchdog allows twice the line time of all frames
	initial
	begin : watchdog
		int cycles;
		int i;
		cycles = 0;
		for (i = 0; i < numTests; i++)
			cycles += (preBytes[i] + 1 + 12 + payLen[i] + 4) * 8 * `RX_BIT_CYCLES;
		repeat (2 * cycles) @(posedge clkRx);
		$display("Watchdog: the run timed out before all frames were checked");
		$display("test failed");
		$finish;
	end

	////////////////////////////////////////
	// Table loop
	initial
	begin : main
		int t;
		int i;
		int expectOk;
		int expectBad;
		arstN = 1'b0;
		rxLine = 1'b0;
		void'($urandom(31));
		repeat (5) @(negedge clkRx);
		arstN = 1'b1;
		for (t = 0; t < numTests; t++)
		begin
			testErrors = 0;
			// Idle level follows the polarity so a stray edge times out here
			rxLine = invertLine[t];
			repeat (idleGap) @(negedge clkRx);
			okBase = okSeen;
			badBase = badSeen;
			byteBase = rxBytes.size();
			inFrameBase = inFrameCycles;
			buildFrame(payLen[t], toStation[t], corruptBit[t]);
			sendFrame(preBytes[t], invertLine[t]);
			waitVerdict();
			expectOk = (verdict[t] == verdictOk) ? 1 : 0;
			expectBad = (verdict[t] == verdictBad) ? 1 : 0;
			if (expectOk == 1)
				expectedCount = expectedCount + 1'b1;
			checkValue(expectOk, okSeen - okBase, "pktOk strobes");
			checkValue(expectBad, badSeen - badBase, "pktBad strobes");
			checkValue(expectedCount, pktCount, "pktCount");
			if (verdict[t] == verdictNone)
			begin
				checkValue(0, inFrameCycles - inFrameBase, "cycles with inFrame high");
				checkValue(0, rxBytes.size() - byteBase, "received bytes");
			end
			else
			begin
				// Bytes after the SFD including the FCS
				checkValue(txBytes.size(), rxBytes.size() - byteBase, "received byte count");
				for (i = 0; i < txBytes.size() && byteBase + i < rxBytes.size(); i++)
					checkValue(32'(txBytes[i]), 32'(rxBytes[byteBase + i]),
						$sformatf("byte %0d", i));
			end
			if (testErrors != 0)
				failedTests++;
			if (testErrors == 0)
				$display("Test %0d, %s: ok", t, testName[t]);
			else
				$display("Test %0d, %s: %0d mismatches", t, testName[t], testErrors);
		end
		$display("%0d tests run, %0d with mismatches, %0d failed checks",
			numTests, failedTests, errorCount);
		if (errorCount == 0)
		begin
			$display("test passed");
		end
		else
		begin
			$display("test failed");
		end
		$finish;
	end

endmodule

/* filelist.f */
+incdir+src
+incdir+bench
src/ethRxPkg.sv
src/manchesterDecoder.sv
src/frameSync.sv
src/crcCheck.sv
src/packetQualifier.sv
src/ethRxTop.sv
bench/ethRxTb.sv

/* run.sh */
#!/bin/sh
# Builds the receiver testbench with Verilator, runs it and judges the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --timescale 1ns/1ps \
	-f filelist.f --top-module ethRxTb \
	-Mdir "$OBJ" -o ethRxSim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$OBJ/ethRxSim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "test failed" "$LOG"; then
	echo "Result: FAIL"
	exit 1
fi

echo "Result: PASS"
exit 0
